/* rtl/rv_core_pkg.sv */
// Core widths, reset address and the enums shared by the datapath and control
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_type_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_TARGET
    } wb_sel_e;

    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_TARGET,
        PC_ALU
    } pc_sel_e;

    typedef enum logic {
        TGT_PC,
        TGT_RS1
    } tgt_sel_e;

    // Encodings follow funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

endpackage

/* rtl/rv_fetch.sv */
// Program counter register and next-PC selection
`timescale 1ns/100ps

module rv_fetch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  rv_core_pkg::pc_sel_e             i_pc_sel,
    input  logic [rv_core_pkg::XLEN-1:0]     i_target,
    input  logic [rv_core_pkg::XLEN-1:0]     i_alu_result,
    output logic [rv_core_pkg::XLEN-1:0]     o_pc
);

    logic [rv_core_pkg::XLEN-1:0] pc_next;

    always_comb begin
        case (i_pc_sel)
            rv_core_pkg::PC_TARGET: pc_next = i_target;
            // JALR target has bit 0 dropped
            rv_core_pkg::PC_ALU:    pc_next = {i_alu_result[rv_core_pkg::XLEN-1:1], 1'b0};
            default:                pc_next = o_pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= rv_core_pkg::RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

    // Every fetch must land on a word boundary
    a_pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) o_pc[1:0] == 2'b00
    ) else $error("fetch address 0x%08h is not word aligned", o_pc);

endmodule

/* rtl/rv_decode.sv */
// Instruction field split, control generation and immediate extension
`timescale 1ns/100ps

module rv_decode (
    input  logic [rv_core_pkg::XLEN-1:0]       i_instr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_core_pkg::XLEN-1:0]       o_imm,
    output rv_core_pkg::alu_op_e               o_alu_op,
    output logic                               o_alu_src_imm,
    output logic                               o_is_branch,
    output logic                               o_is_jal,
    output logic                               o_is_jalr,
    output rv_core_pkg::tgt_sel_e              o_tgt_sel,
    output rv_core_pkg::wb_sel_e               o_wb_sel,
    output logic                               o_reg_write,
    output logic                               o_mem_read,
    output logic                               o_mem_write,
    output rv_core_pkg::mem_size_e             o_mem_size,
    output logic [2:0]                         o_funct3
);

    rv_core_pkg::opcode_e   opcode;
    rv_core_pkg::imm_type_e imm_type;
    rv_core_pkg::alu_op_e   arith_op;
    logic [2:0]             funct3;
    logic                   sub_en;

    assign opcode   = rv_core_pkg::opcode_e'(i_instr[6:0]);
    assign funct3   = i_instr[14:12];
    assign o_rd     = i_instr[11:7];
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_funct3 = funct3;
    assign o_mem_size = rv_core_pkg::mem_size_e'(funct3);

    // SUB exists only in the register form, SRA/SRAI in both
    assign sub_en = (opcode == rv_core_pkg::OPC_OP) && i_instr[30];

    always_comb begin
        case (funct3)
            3'b000:  arith_op = sub_en ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  arith_op = rv_core_pkg::ALU_SLL;
            3'b010:  arith_op = rv_core_pkg::ALU_SLT;
            3'b011:  arith_op = rv_core_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_core_pkg::ALU_XOR;
            3'b101:  arith_op = i_instr[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  arith_op = rv_core_pkg::ALU_OR;
            default: arith_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        // Unknown opcodes fall through as a no-op
        imm_type      = rv_core_pkg::IMM_I;
        o_alu_op      = rv_core_pkg::ALU_ADD;
        o_alu_src_imm = 1'b0;
        o_is_branch   = 1'b0;
        o_is_jal      = 1'b0;
        o_is_jalr     = 1'b0;
        o_tgt_sel     = rv_core_pkg::TGT_PC;
        o_wb_sel      = rv_core_pkg::WB_ALU;
        o_reg_write   = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                imm_type      = rv_core_pkg::IMM_U;
                o_alu_op      = rv_core_pkg::ALU_PASS;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                imm_type    = rv_core_pkg::IMM_U;
                o_wb_sel    = rv_core_pkg::WB_TARGET;
                o_reg_write = 1'b1;
            end
            rv_core_pkg::OPC_JAL: begin
                imm_type    = rv_core_pkg::IMM_J;
                o_is_jal    = 1'b1;
                o_wb_sel    = rv_core_pkg::WB_PC4;
                o_reg_write = 1'b1;
            end
            rv_core_pkg::OPC_JALR: begin
                o_alu_src_imm = 1'b1;
                o_is_jalr     = 1'b1;
                o_tgt_sel     = rv_core_pkg::TGT_RS1;
                o_wb_sel      = rv_core_pkg::WB_PC4;
                o_reg_write   = 1'b1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm_type    = rv_core_pkg::IMM_B;
                o_is_branch = 1'b1;
            end
            rv_core_pkg::OPC_LOAD: begin
                o_alu_src_imm = 1'b1;
                o_mem_read    = 1'b1;
                o_wb_sel      = rv_core_pkg::WB_LOAD;
                o_reg_write   = 1'b1;
            end
            rv_core_pkg::OPC_STORE: begin
                imm_type      = rv_core_pkg::IMM_S;
                o_alu_src_imm = 1'b1;
                o_mem_write   = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                o_alu_op      = arith_op;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            rv_core_pkg::OPC_OP: begin
                o_alu_op    = arith_op;
                o_reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_type)
            rv_core_pkg::IMM_S: o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            rv_core_pkg::IMM_B: o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                         i_instr[30:25], i_instr[11:8], 1'b0};
            rv_core_pkg::IMM_U: o_imm = {i_instr[31:12], 12'b0};
            rv_core_pkg::IMM_J: o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                         i_instr[20], i_instr[30:21], 1'b0};
            default:            o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

/* rtl/rv_regfile.sv */
// 32-entry register file, two async reads and one clocked write
`timescale 1ns/100ps

module rv_regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic                               i_we,
    input  logic [rv_core_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_core_pkg::XLEN-1:0]       o_rdata1,
    output logic [rv_core_pkg::XLEN-1:0]       o_rdata2
);

    logic [rv_core_pkg::XLEN-1:0] regs [2**rv_core_pkg::REG_ADDR_W];

    // No write lands while in reset, x0 never takes one
    always_ff @(posedge clk) begin
        if (rst_n && i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* rtl/rv_execute.sv */
// ALU, branch compare, target adder, next-PC and write-back select
`timescale 1ns/100ps

module rv_execute (
    input  logic [rv_core_pkg::XLEN-1:0] i_pc,
    input  logic [rv_core_pkg::XLEN-1:0] i_rdata1,
    input  logic [rv_core_pkg::XLEN-1:0] i_rdata2,
    input  logic [rv_core_pkg::XLEN-1:0] i_imm,
    input  rv_core_pkg::alu_op_e         i_alu_op,
    input  logic                         i_alu_src_imm,
    input  logic [2:0]                   i_funct3,
    input  logic                         i_is_branch,
    input  logic                         i_is_jal,
    input  logic                         i_is_jalr,
    input  rv_core_pkg::tgt_sel_e        i_tgt_sel,
    input  rv_core_pkg::wb_sel_e         i_wb_sel,
    input  logic                         i_reg_write,
    input  logic [rv_core_pkg::XLEN-1:0] i_load_data,
    output logic [rv_core_pkg::XLEN-1:0] o_alu_result,
    output logic [rv_core_pkg::XLEN-1:0] o_target,
    output rv_core_pkg::pc_sel_e         o_pc_sel,
    output logic                         o_rd_we,
    output logic [rv_core_pkg::XLEN-1:0] o_rd_wdata
);

    logic [rv_core_pkg::XLEN-1:0] op_b;
    logic [rv_core_pkg::XLEN-1:0] pc_plus4;
    logic [4:0]                   shamt;
    logic                         taken;

    assign op_b     = i_alu_src_imm ? i_imm : i_rdata2;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = i_pc + 32'd4;

    always_comb begin
        case (i_alu_op)
            rv_core_pkg::ALU_SUB:  o_alu_result = i_rdata1 - op_b;
            rv_core_pkg::ALU_AND:  o_alu_result = i_rdata1 & op_b;
            rv_core_pkg::ALU_OR:   o_alu_result = i_rdata1 | op_b;
            rv_core_pkg::ALU_XOR:  o_alu_result = i_rdata1 ^ op_b;
            rv_core_pkg::ALU_SLL:  o_alu_result = i_rdata1 << shamt;
            rv_core_pkg::ALU_SRL:  o_alu_result = i_rdata1 >> shamt;
            rv_core_pkg::ALU_SRA:  o_alu_result = $signed(i_rdata1) >>> shamt;
            rv_core_pkg::ALU_SLT:  o_alu_result = {31'b0, $signed(i_rdata1) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU: o_alu_result = {31'b0, i_rdata1 < op_b};
            rv_core_pkg::ALU_PASS: o_alu_result = op_b;
            default:               o_alu_result = i_rdata1 + op_b;
        endcase
    end

    // Branch conditions straight from funct3
    always_comb begin
        case (i_funct3)
            3'b000:  taken = (i_rdata1 == i_rdata2);
            3'b001:  taken = (i_rdata1 != i_rdata2);
            3'b100:  taken = ($signed(i_rdata1) < $signed(i_rdata2));
            3'b101:  taken = ($signed(i_rdata1) >= $signed(i_rdata2));
            3'b110:  taken = (i_rdata1 < i_rdata2);
            3'b111:  taken = (i_rdata1 >= i_rdata2);
            default: taken = 1'b0;
        endcase
    end

    assign o_target = ((i_tgt_sel == rv_core_pkg::TGT_RS1) ? i_rdata1 : i_pc) + i_imm;

    always_comb begin
        if (i_is_jalr) begin
            o_pc_sel = rv_core_pkg::PC_ALU;
        end else if (i_is_jal || (i_is_branch && taken)) begin
            o_pc_sel = rv_core_pkg::PC_TARGET;
        end else begin
            o_pc_sel = rv_core_pkg::PC_PLUS4;
        end
    end

    always_comb begin
        case (i_wb_sel)
            rv_core_pkg::WB_LOAD:   o_rd_wdata = i_load_data;
            rv_core_pkg::WB_PC4:    o_rd_wdata = pc_plus4;
            rv_core_pkg::WB_TARGET: o_rd_wdata = o_target;
            default:                o_rd_wdata = o_alu_result;
        endcase
    end

    assign o_rd_we = i_reg_write;

endmodule

/* rtl/rv_lsu.sv */
// Store lane steering and byte enables, load lane select and extension
`timescale 1ns/100ps

module rv_lsu (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [rv_core_pkg::XLEN-1:0] i_addr,
    input  logic [rv_core_pkg::XLEN-1:0] i_store_data,
    input  logic                         i_mem_read,
    input  logic                         i_mem_write,
    input  rv_core_pkg::mem_size_e       i_mem_size,
    input  logic [rv_core_pkg::XLEN-1:0] i_dmem_rdata,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_addr,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_wdata,
    output logic [3:0]                   o_dmem_be,
    output logic                         o_dmem_we,
    output logic                         o_dmem_re,
    output logic [rv_core_pkg::XLEN-1:0] o_load_data
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign o_dmem_addr = i_addr;
    // Strobes stay low for as long as reset is held
    assign o_dmem_we   = i_mem_write && rst_n;
    assign o_dmem_re   = i_mem_read && rst_n;

    always_comb begin
        case (i_mem_size)
            rv_core_pkg::MEM_B: begin
                o_dmem_wdata = {4{i_store_data[7:0]}};
                o_dmem_be    = 4'b0001 << i_addr[1:0];
            end
            rv_core_pkg::MEM_H: begin
                o_dmem_wdata = {2{i_store_data[15:0]}};
                o_dmem_be    = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_dmem_wdata = i_store_data;
                o_dmem_be    = 4'b1111;
            end
        endcase
    end

    assign ld_byte = i_dmem_rdata[8*i_addr[1:0] +: 8];
    assign ld_half = i_addr[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];

    always_comb begin
        case (i_mem_size)
            rv_core_pkg::MEM_B:  o_load_data = {{24{ld_byte[7]}}, ld_byte};
            rv_core_pkg::MEM_BU: o_load_data = {24'b0, ld_byte};
            rv_core_pkg::MEM_H:  o_load_data = {{16{ld_half[15]}}, ld_half};
            rv_core_pkg::MEM_HU: o_load_data = {16'b0, ld_half};
            default:             o_load_data = i_dmem_rdata;
        endcase
    end

    // No trap path, so misaligned accesses are caught here in simulation
    a_half_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((o_dmem_we || o_dmem_re) && (i_mem_size inside {rv_core_pkg::MEM_H, rv_core_pkg::MEM_HU}))
            |-> (i_addr[0] == 1'b0)
    ) else $error("half access at 0x%08h is misaligned", i_addr);

    a_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((o_dmem_we || o_dmem_re) && (i_mem_size == rv_core_pkg::MEM_W))
            |-> (i_addr[1:0] == 2'b00)
    ) else $error("word access at 0x%08h is misaligned", i_addr);

endmodule

/* rtl/rv_core.sv */
// Single-cycle RV32I core top with instruction and data memory ports
`timescale 1ns/100ps

module rv_core (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic [rv_core_pkg::XLEN-1:0] o_imem_addr,
    input  logic [rv_core_pkg::XLEN-1:0] i_imem_rdata,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_addr,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_wdata,
    output logic [3:0]                   o_dmem_be,
    output logic                         o_dmem_we,
    output logic                         o_dmem_re,
    input  logic [rv_core_pkg::XLEN-1:0] i_dmem_rdata
);

    logic [rv_core_pkg::XLEN-1:0]       pc;
    logic [rv_core_pkg::XLEN-1:0]       imm;
    logic [rv_core_pkg::XLEN-1:0]       rdata1;
    logic [rv_core_pkg::XLEN-1:0]       rdata2;
    logic [rv_core_pkg::XLEN-1:0]       alu_result;
    logic [rv_core_pkg::XLEN-1:0]       target;
    logic [rv_core_pkg::XLEN-1:0]       load_data;
    logic [rv_core_pkg::XLEN-1:0]       rd_wdata;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic [2:0]                         funct3;
    logic                               alu_src_imm;
    logic                               is_branch;
    logic                               is_jal;
    logic                               is_jalr;
    logic                               reg_write;
    logic                               rd_we;
    logic                               mem_read;
    logic                               mem_write;
    rv_core_pkg::alu_op_e               alu_op;
    rv_core_pkg::tgt_sel_e              tgt_sel;
    rv_core_pkg::wb_sel_e               wb_sel;
    rv_core_pkg::pc_sel_e               pc_sel;
    rv_core_pkg::mem_size_e             mem_size;

    assign o_imem_addr = pc;

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n),
        .i_pc_sel(pc_sel), .i_target(target), .i_alu_result(alu_result),
        .o_pc(pc)
    );

    rv_decode u_decode (
        .i_instr(i_imem_rdata),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_alu_src_imm(alu_src_imm),
        .o_is_branch(is_branch), .o_is_jal(is_jal), .o_is_jalr(is_jalr),
        .o_tgt_sel(tgt_sel), .o_wb_sel(wb_sel), .o_reg_write(reg_write),
        .o_mem_read(mem_read), .o_mem_write(mem_write), .o_mem_size(mem_size),
        .o_funct3(funct3)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(rd_we), .i_wdata(rd_wdata),
        .o_rdata1(rdata1), .o_rdata2(rdata2)
    );

    rv_execute u_execute (
        .i_pc(pc), .i_rdata1(rdata1), .i_rdata2(rdata2), .i_imm(imm),
        .i_alu_op(alu_op), .i_alu_src_imm(alu_src_imm), .i_funct3(funct3),
        .i_is_branch(is_branch), .i_is_jal(is_jal), .i_is_jalr(is_jalr),
        .i_tgt_sel(tgt_sel), .i_wb_sel(wb_sel), .i_reg_write(reg_write),
        .i_load_data(load_data),
        .o_alu_result(alu_result), .o_target(target), .o_pc_sel(pc_sel),
        .o_rd_we(rd_we), .o_rd_wdata(rd_wdata)
    );

    rv_lsu u_lsu (
        .clk(clk), .rst_n(rst_n),
        .i_addr(alu_result), .i_store_data(rdata2),
        .i_mem_read(mem_read), .i_mem_write(mem_write), .i_mem_size(mem_size),
        .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata), .o_dmem_be(o_dmem_be),
        .o_dmem_we(o_dmem_we), .o_dmem_re(o_dmem_re),
        .o_load_data(load_data)
    );

endmodule

/* dv/rv_core_tb_prog.svh */
// Instruction encoders, LFSR random source, data fill and test program builder
`ifndef RV_CORE_TB_PROG_SVH
`define RV_CORE_TB_PROG_SVH

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
endfunction

function automatic void emit(logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int b = 0; b < 32; b++) begin
        w[b] = lfsr_bit();
    end
    return w;
endfunction

task automatic fill_data();
    lfsr_state = 16'd48;
    for (int i = 0; i < 256; i++) begin
        dmem[i] = rand_word() ^ 32'(i);
    end
endtask

task automatic build_program();
    logic [11:0] imm;
    prog_len = 0;
    // A store sits at the reset address so that reset must hold its strobe low
    emit(enc_s(12'h200, 5'd0, 5'd0, 3'b010));
    // x1 scratch base for result stores, x3 and x4 are the operands
    emit(enc_i(12'h200, 5'd0, 3'b000, 5'd1, rv_core_pkg::OPC_OP_IMM));
    emit(enc_u(20'h87654, 5'd3, rv_core_pkg::OPC_LUI));
    emit(enc_i(12'h321, 5'd3, 3'b000, 5'd3, rv_core_pkg::OPC_OP_IMM));
    emit(enc_i(12'hFFB, 5'd0, 3'b000, 5'd4, rv_core_pkg::OPC_OP_IMM));
    emit(enc_s(12'd0, 5'd3, 5'd1, 3'b010));
    // Register ops in both operand orders, f == 8 is SUB and f == 13 is SRA
    for (int f = 0; f < 16; f++) begin
        if (f >= 8 && f != 8 && f != 13) begin
            continue;
        end
        emit(enc_r((f >= 8) ? 7'h20 : 7'h00, 5'd4, 5'd3, 3'(f), 5'd5));
        emit(enc_s(12'd0, 5'd5, 5'd1, 3'b010));
        emit(enc_r((f >= 8) ? 7'h20 : 7'h00, 5'd3, 5'd4, 3'(f), 5'd5));
        emit(enc_s(12'd0, 5'd5, 5'd1, 3'b010));
    end
    // Immediate ops, f == 8 is SRAI
    for (int f = 0; f < 9; f++) begin
        if (f == 8) begin
            imm = 12'h407;
        end else if (f == 1 || f == 5) begin
            imm = 12'h007;
        end else begin
            imm = 12'hED4;
        end
        emit(enc_i(imm, 5'd3, (f == 8) ? 3'b101 : 3'(f), 5'd6, rv_core_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd6, 5'd1, 3'b010));
    end
    emit(enc_u(20'h12345, 5'd5, rv_core_pkg::OPC_AUIPC));
    emit(enc_s(12'd0, 5'd5, 5'd1, 3'b010));
    // Write to x0 must vanish
    emit(enc_i(12'd1, 5'd3, 3'b000, 5'd0, rv_core_pkg::OPC_OP_IMM));
    emit(enc_s(12'd0, 5'd0, 5'd1, 3'b010));
    // x6 counts branches that fall through
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd6, rv_core_pkg::OPC_OP_IMM));
    for (int f = 0; f < 8; f++) begin
        if (f == 2 || f == 3) begin
            continue;
        end
        for (int k = 0; k < 3; k++) begin
            emit(enc_b(13'd8, (k == 0) ? 5'd4 : 5'd3, (k == 1) ? 5'd4 : 5'd3, 3'(f)));
            emit(enc_i(12'd1, 5'd6, 3'b000, 5'd6, rv_core_pkg::OPC_OP_IMM));
        end
    end
    emit(enc_s(12'd0, 5'd6, 5'd1, 3'b010));
    emit(enc_j(21'd8, 5'd7));
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd7, rv_core_pkg::OPC_OP_IMM));
    emit(enc_s(12'd0, 5'd7, 5'd1, 3'b010));
    // JALR with an odd offset lands on the word after two skipped slots
    emit(enc_u(20'd0, 5'd8, rv_core_pkg::OPC_AUIPC));
    emit(enc_i(12'd17, 5'd8, 3'b000, 5'd9, rv_core_pkg::OPC_JALR));
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd9, rv_core_pkg::OPC_OP_IMM));
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd9, rv_core_pkg::OPC_OP_IMM));
    emit(enc_s(12'd0, 5'd9, 5'd1, 3'b010));
    for (int k = 0; k < 4; k++) begin
        emit(enc_s(12'(4 + k), 5'd3, 5'd1, 3'b000));
        if (k % 2 == 0) begin
            emit(enc_s(12'(4 + k), 5'd3, 5'd1, 3'b001));
        end
    end
    emit(enc_s(12'd4, 5'd3, 5'd1, 3'b010));
    // Loads from the random region, each result stored back for checking
    for (int k = 0; k < 4; k++) begin
        emit(enc_i(12'(16 + k), 5'd0, 3'b000, 5'd10, rv_core_pkg::OPC_LOAD));
        emit(enc_s(12'd0, 5'd10, 5'd1, 3'b010));
        emit(enc_i(12'(20 + k), 5'd0, 3'b100, 5'd10, rv_core_pkg::OPC_LOAD));
        emit(enc_s(12'd0, 5'd10, 5'd1, 3'b010));
        if (k % 2 == 0) begin
            emit(enc_i(12'(32 + k), 5'd0, 3'b001, 5'd10, rv_core_pkg::OPC_LOAD));
            emit(enc_s(12'd0, 5'd10, 5'd1, 3'b010));
            emit(enc_i(12'(36 + k), 5'd0, 3'b101, 5'd10, rv_core_pkg::OPC_LOAD));
            emit(enc_s(12'd0, 5'd10, 5'd1, 3'b010));
        end
    end
    emit(enc_i(12'd48, 5'd0, 3'b010, 5'd10, rv_core_pkg::OPC_LOAD));
    emit(enc_s(12'd0, 5'd10, 5'd1, 3'b010));
    end_pc = 32'(prog_len * 4);
    emit(enc_j(21'd0, 5'd0));
    cycle_limit = 4 * prog_len + 20;
endtask

`endif

/* dv/rv_core_tb.sv */
// Testbench for the single-cycle core with memories, reference model and assertions
`timescale 1ns/100ps

module rv_core_tb;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_be;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [15:0] lfsr_state;
    logic [31:0] end_pc;
    int          prog_len;
    int          cycle_limit;
    int          cycles = 0;
    int          error_count = 0;

    // Reference model state and what it expects this cycle
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] instr;
    logic [31:0] exp_next;
    logic        exp_wr;
    logic [31:0] exp_wval;
    logic        exp_we;
    logic        exp_re;
    logic [31:0] exp_addr;
    logic [3:0]  exp_be;
    logic [31:0] exp_wdata;

    `include "rv_core_tb_prog.svh"

    always #5 clk = ~clk;

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    rv_core i_dut (
        .clk(clk), .rst_n(rst_n),
        .o_imem_addr(imem_addr), .i_imem_rdata(imem_rdata),
        .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_be(dmem_be),
        .o_dmem_we(dmem_we), .o_dmem_re(dmem_re), .i_dmem_rdata(dmem_rdata)
    );

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_be[b]) begin
                    dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] x,
                                            logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b110:  return x | y;
            3'b111:  return x & y;
            default: begin
                // Right shift, arithmetic when alt is set
                if (alt) begin
                    return $signed(x) >>> y[4:0];
                end
                return x >> y[4:0];
            end
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] imm_i;
        logic [31:0] lane;
        logic [2:0]  f3;
        instr     = imem[m_pc[9:2]];
        rs1v      = m_regs[instr[19:15]];
        rs2v      = m_regs[instr[24:20]];
        f3        = instr[14:12];
        imm_i     = {{20{instr[31]}}, instr[31:20]};
        exp_next  = m_pc + 32'd4;
        exp_wr    = 1'b0;
        exp_wval  = '0;
        exp_we    = 1'b0;
        exp_re    = 1'b0;
        exp_addr  = '0;
        exp_be    = '0;
        exp_wdata = '0;
        lane      = '0;
        case (instr[6:0])
            rv_core_pkg::OPC_LUI: begin
                exp_wr   = 1'b1;
                exp_wval = {instr[31:12], 12'h000};
            end
            rv_core_pkg::OPC_AUIPC: begin
                exp_wr   = 1'b1;
                exp_wval = m_pc + {instr[31:12], 12'h000};
            end
            rv_core_pkg::OPC_JAL: begin
                exp_wr   = 1'b1;
                exp_wval = m_pc + 32'd4;
                exp_next = m_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            rv_core_pkg::OPC_JALR: begin
                exp_wr   = 1'b1;
                exp_wval = m_pc + 32'd4;
                exp_next = (rs1v + imm_i) & ~32'd1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                if (branch_ref(f3, rs1v, rs2v)) begin
                    exp_next = m_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
            end
            rv_core_pkg::OPC_LOAD: begin
                exp_re   = 1'b1;
                exp_wr   = 1'b1;
                exp_addr = rs1v + imm_i;
                lane     = dmem[exp_addr[9:2]] >> (8 * exp_addr[1:0]);
                case (f3)
                    3'b000:  exp_wval = {{24{lane[7]}}, lane[7:0]};
                    3'b100:  exp_wval = {24'h0, lane[7:0]};
                    3'b001:  exp_wval = {{16{lane[15]}}, lane[15:0]};
                    3'b101:  exp_wval = {16'h0, lane[15:0]};
                    default: exp_wval = lane;
                endcase
            end
            rv_core_pkg::OPC_STORE: begin
                exp_we   = 1'b1;
                exp_addr = rs1v + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                // Lane k enabled when it falls in the access; data repeats per access size
                for (int k = 0; k < 4; k++) begin
                    exp_be[k] = (k >> f3[1:0]) == (exp_addr[1:0] >> f3[1:0]);
                    exp_wdata[8*k +: 8] = rs2v[8*(k % (1 << f3[1:0])) +: 8];
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                exp_wr   = 1'b1;
                exp_wval = alu_ref(f3, instr[30] && (f3 == 3'b101), rs1v, imm_i);
            end
            rv_core_pkg::OPC_OP: begin
                exp_wr   = 1'b1;
                exp_wval = alu_ref(f3, instr[30], rs1v, rs2v);
            end
            default: ;
        endcase
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            m_pc <= rv_core_pkg::RESET_PC;
        end else begin
            m_pc <= exp_next;
            if (exp_wr && (instr[11:7] != 5'd0)) begin
                m_regs[instr[11:7]] <= exp_wval;
            end
        end
    end

    task automatic report_mismatch(string check, logic [31:0] expected, logic [31:0] actual);
        error_count++;
        $display("** Error %s at %0t: expected 0x%08h, actual 0x%08h",
                 check, $time, expected, actual);
    endtask

    a_reset_pc: assert property (@(posedge clk) !rst_n |=> imem_addr == rv_core_pkg::RESET_PC)
        else report_mismatch("reset_pc", rv_core_pkg::RESET_PC, $sampled(imem_addr));
    a_reset_strobes: assert property (@(posedge clk) !rst_n |-> !dmem_we && !dmem_re)
        else report_mismatch("reset_strobes", 32'd0, {30'd0, $sampled(dmem_we), $sampled(dmem_re)});
    a_next_pc: assert property (@(posedge clk) disable iff (!rst_n) imem_addr == m_pc)
        else report_mismatch("next_pc", $sampled(m_pc), $sampled(imem_addr));
    a_store_strobe: assert property (@(posedge clk) disable iff (!rst_n) dmem_we == exp_we)
        else report_mismatch("store_strobe", 32'($sampled(exp_we)), 32'($sampled(dmem_we)));
    a_load_strobe: assert property (@(posedge clk) disable iff (!rst_n) dmem_re == exp_re)
        else report_mismatch("load_strobe", 32'($sampled(exp_re)), 32'($sampled(dmem_re)));
    a_mem_addr: assert property (
        @(posedge clk) disable iff (!rst_n) (exp_we || exp_re) |-> dmem_addr == exp_addr
    ) else report_mismatch("mem_addr", $sampled(exp_addr), $sampled(dmem_addr));
    a_store_be: assert property (@(posedge clk) disable iff (!rst_n) exp_we |-> dmem_be == exp_be)
        else report_mismatch("store_be", 32'($sampled(exp_be)), 32'($sampled(dmem_be)));
    a_store_wdata: assert property (
        @(posedge clk) disable iff (!rst_n) exp_we |-> dmem_wdata == exp_wdata
    ) else report_mismatch("store_wdata", $sampled(exp_wdata), $sampled(dmem_wdata));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the program never reached its final loop", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        m_regs[0] = '0;
        fill_data();
        build_program();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        while (imem_addr != end_pc) begin
            @(posedge clk);
        end
        // Let the checks on the last instructions fire
        repeat (2) @(posedge clk);
        $display("Run ended after %0d cycles with %0d errors", cycles, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+dv
rtl/rv_core_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
dv/rv_core_tb.sv
